/* logic/cache_pkg.sv */
`default_nettype none

package cache_pkg;

  localparam int ADDR_WIDTH    = 32;  // byte address
  localparam int DATA_WIDTH    = 32;  // cpu and memory word
  localparam int BE_WIDTH      = DATA_WIDTH / 8;

  // line geometry
  localparam int LINE_WORDS    = 4;   // also beats per burst
  localparam int WORD_IDX_BITS = $clog2(LINE_WORDS);
  localparam int BYTE_OFF_BITS = $clog2(BE_WIDTH);

  localparam int WAY_COUNT     = 4;
  localparam int WAY_BITS      = $clog2(WAY_COUNT);

endpackage

`default_nettype wire

/* logic/way_bus_if.sv */
`default_nettype none

interface way_bus_if #(
  parameter int line_count = 16
);

  localparam int index_bits = $clog2(line_count);
  localparam int tag_bits   = cache_pkg::ADDR_WIDTH - index_bits
                              - cache_pkg::WORD_IDX_BITS - cache_pkg::BYTE_OFF_BITS;

  // way storage status
  logic                                hit;
  logic                                victim_dirty;
  logic                                victim_valid;
  logic [tag_bits-1:0]                 victim_tag;
  logic [cache_pkg::DATA_WIDTH-1:0]    line_word;  // victim word at fill_count

  // controller strobes
  logic                                fill_start;
  logic                                fill_word;
  logic                                fill_done;
  logic [cache_pkg::WORD_IDX_BITS-1:0] fill_count;
  logic                                evict;

  modport ctrl (
    input  hit, victim_dirty, victim_valid, victim_tag, line_word,
    output fill_start, fill_word, fill_done, fill_count, evict
  );

  modport ways (
    output hit, victim_dirty, victim_valid, victim_tag, line_word,
    input  fill_start, fill_word, fill_done, fill_count, evict
  );

endinterface

`default_nettype wire

/* logic/victim_select.sv */
`default_nettype none

module victim_select #(
  parameter logic [10:0] lfsr_seed = 11'd101
) (
  input  wire                                clock,
  input  wire                                reset_n,
  input  wire  [cache_pkg::WAY_COUNT-1:0]    set_valid,
  input  wire  [cache_pkg::WAY_COUNT-1:0]    set_dirty,
  input  wire                                advance,
  output logic [cache_pkg::WAY_BITS-1:0]     victim_way
);

  logic [10:0]                    lfsr;
  logic [cache_pkg::WAY_BITS-1:0] start;

  // x^11 + x^9 + 1 taps stepped twice per advance
  always_ff @(posedge clock or negedge reset_n) begin
    if (!reset_n)
      lfsr <= lfsr_seed;
    else if (advance)
      lfsr <= {lfsr[1] ^ lfsr[3], lfsr[0] ^ lfsr[2], lfsr[10:2]};
  end

  assign start = lfsr[cache_pkg::WAY_BITS-1:0];

  always_comb begin
    logic                           found;
    logic [cache_pkg::WAY_BITS-1:0] cand;
    found      = 1'b0;
    victim_way = start;  // random pick when every way is dirty
    for (int i = 0; i < cache_pkg::WAY_COUNT; i++) begin
      if (!found && !set_valid[i]) begin
        victim_way = cache_pkg::WAY_BITS'(i);
        found      = 1'b1;
      end
    end
    // clean way searched upward from start+1 with wrap
    for (int k = 1; k <= cache_pkg::WAY_COUNT; k++) begin
      cand = start + cache_pkg::WAY_BITS'(k);
      if (!found && !set_dirty[cand]) begin
        victim_way = cand;
        found      = 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

/* logic/cache_ways.sv */
`default_nettype none

module cache_ways #(
  parameter int          line_count = 16,
  parameter logic [10:0] lfsr_seed  = 11'd101
) (
  input  wire                                clock,
  input  wire                                reset_n,

  input  wire  [cache_pkg::ADDR_WIDTH-1:0]   cpu_addr,
  input  wire                                cpu_rd,
  input  wire                                cpu_wr,
  input  wire  [cache_pkg::BE_WIDTH-1:0]     cpu_wr_be,
  input  wire  [cache_pkg::DATA_WIDTH-1:0]   cpu_wr_data,
  input  wire  [cache_pkg::DATA_WIDTH-1:0]   mem_rd_data,
  output logic [cache_pkg::DATA_WIDTH-1:0]   cpu_rd_data,

  way_bus_if.ways                            bus
);

  localparam int index_bits = $clog2(line_count);
  localparam int line_off   = cache_pkg::WORD_IDX_BITS + cache_pkg::BYTE_OFF_BITS;
  localparam int tag_bits   = cache_pkg::ADDR_WIDTH - index_bits - line_off;

  logic [line_count-1:0]            valid_q [cache_pkg::WAY_COUNT];
  logic [line_count-1:0]            dirty_q [cache_pkg::WAY_COUNT];
  logic [tag_bits-1:0]              tag_q   [cache_pkg::WAY_COUNT][line_count];
  logic [cache_pkg::DATA_WIDTH-1:0] data_q
    [cache_pkg::WAY_COUNT][line_count][cache_pkg::LINE_WORDS];

  logic [index_bits-1:0]               cpu_index;
  logic [tag_bits-1:0]                 cpu_tag;
  logic [cache_pkg::WORD_IDX_BITS-1:0] cpu_word;

  logic [cache_pkg::WAY_COUNT-1:0]     way_hit;
  logic [cache_pkg::WAY_COUNT-1:0]     set_valid;
  logic [cache_pkg::WAY_COUNT-1:0]     set_dirty;
  logic [cache_pkg::WAY_BITS-1:0]      hit_way;
  logic [cache_pkg::WAY_BITS-1:0]      victim_way;
  logic [cache_pkg::WAY_BITS-1:0]      held_way;
  logic [cache_pkg::WAY_BITS-1:0]      cur_way;
  logic                                held;
  logic                                write_hit;

  assign cpu_index = cpu_addr[line_off +: index_bits];
  assign cpu_tag   = cpu_addr[cache_pkg::ADDR_WIDTH-1 -: tag_bits];
  assign cpu_word  = cpu_addr[cache_pkg::BYTE_OFF_BITS +: cache_pkg::WORD_IDX_BITS];

  always_comb begin
    hit_way = '0;
    for (int w = 0; w < cache_pkg::WAY_COUNT; w++) begin
      set_valid[w] = valid_q[w][cpu_index];
      set_dirty[w] = dirty_q[w][cpu_index];
      way_hit[w]   = valid_q[w][cpu_index] && (tag_q[w][cpu_index] == cpu_tag);
      if (way_hit[w])
        hit_way = cache_pkg::WAY_BITS'(w);
    end
  end

  assign bus.hit     = (cpu_rd | cpu_wr) & (|way_hit);
  assign write_hit   = cpu_wr & bus.hit;
  assign cpu_rd_data = data_q[hit_way][cpu_index][cpu_word];

  // victim stays fixed while its line is being filled
  assign cur_way = held ? held_way : victim_way;

  assign bus.victim_valid = valid_q[cur_way][cpu_index];
  assign bus.victim_dirty = dirty_q[cur_way][cpu_index];
  assign bus.victim_tag   = tag_q[cur_way][cpu_index];
  assign bus.line_word    = data_q[cur_way][cpu_index][bus.fill_count];

  victim_select #(.lfsr_seed(lfsr_seed)) victim_select_i (
    .clock      (clock),
    .reset_n    (reset_n),
    .set_valid  (set_valid),
    .set_dirty  (set_dirty),
    .advance    (bus.fill_start),
    .victim_way (victim_way)
  );

  always_ff @(posedge clock or negedge reset_n) begin
    if (!reset_n) begin
      for (int w = 0; w < cache_pkg::WAY_COUNT; w++) begin
        valid_q[w] <= '0;
        dirty_q[w] <= '0;
      end
      held     <= 1'b0;
      held_way <= '0;
    end else begin
      if (write_hit)
        dirty_q[hit_way][cpu_index] <= 1'b1;
      if (bus.evict || bus.fill_start) begin
        valid_q[cur_way][cpu_index] <= 1'b0;
        dirty_q[cur_way][cpu_index] <= 1'b0;
      end
      if (bus.fill_done)
        valid_q[cur_way][cpu_index] <= 1'b1;  // line usable next cycle
      if (bus.fill_start) begin
        held     <= 1'b1;
        held_way <= victim_way;
      end else if (bus.fill_done) begin
        held <= 1'b0;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (bus.fill_start)
      tag_q[cur_way][cpu_index] <= cpu_tag;
    if (bus.fill_word)
      data_q[cur_way][cpu_index][bus.fill_count] <= mem_rd_data;
    if (write_hit) begin
      for (int b = 0; b < cache_pkg::BE_WIDTH; b++) begin
        if (cpu_wr_be[b])
          data_q[hit_way][cpu_index][cpu_word][8*b +: 8] <= cpu_wr_data[8*b +: 8];
      end
    end
  end

endmodule

`default_nettype wire

/* logic/cache_ctrl.sv */
`default_nettype none

module cache_ctrl #(
  parameter int line_count = 16
) (
  input  wire                                 clock,
  input  wire                                 reset_n,

  input  wire  [cache_pkg::ADDR_WIDTH-1:0]    cpu_addr,
  input  wire                                 cpu_rd,
  input  wire                                 cpu_wr,
  output logic                                cpu_waitrequest,
  output logic                                cpu_rd_valid,

  input  wire                                 mem_rd_valid,
  input  wire                                 mem_waitrequest,
  output logic [cache_pkg::ADDR_WIDTH-1:0]    mem_addr_r,
  output logic                                mem_rd_r,
  output logic                                mem_wr_r,
  output logic [cache_pkg::DATA_WIDTH-1:0]    mem_wr_data_r,

  way_bus_if.ctrl                             bus
);

  localparam int index_bits = $clog2(line_count);
  localparam int line_off   = cache_pkg::WORD_IDX_BITS + cache_pkg::BYTE_OFF_BITS;

  typedef enum logic [1:0] {
    idle,
    writeback,
    allocate
  } state_t;

  state_t                              state;
  state_t                              next_state;
  logic [cache_pkg::WORD_IDX_BITS-1:0] cnt;  // shared beat counter
  logic                                request;
  logic                                last_word;
  logic                                wr_accept;
  logic [index_bits-1:0]               cpu_index;

  assign request   = cpu_rd | cpu_wr;
  assign cpu_index = cpu_addr[line_off +: index_bits];
  assign last_word = (cnt == cache_pkg::WORD_IDX_BITS'(cache_pkg::LINE_WORDS - 1));
  assign wr_accept = (state == writeback) & mem_wr_r & ~mem_waitrequest;

  assign cpu_waitrequest = request & ~bus.hit;
  assign cpu_rd_valid    = cpu_rd & bus.hit;

  // writeback looks one word ahead so the next word is ready on accept
  assign bus.fill_count = (state == writeback) ? cnt + 1'b1 : cnt;
  assign bus.fill_word  = (state == allocate) & mem_rd_valid;
  assign bus.fill_done  = bus.fill_word & last_word;

  always_comb begin
    next_state     = state;
    bus.evict      = 1'b0;
    bus.fill_start = 1'b0;
    case (state)
      idle: begin
        if (request && !bus.hit) begin
          if (bus.victim_valid && bus.victim_dirty) begin
            bus.evict  = 1'b1;
            next_state = writeback;
          end else begin
            bus.fill_start = 1'b1;
            next_state     = allocate;
          end
        end
      end
      writeback: begin
        if (wr_accept && last_word) begin  // last word gone
          bus.fill_start = 1'b1;
          next_state     = allocate;
        end
      end
      allocate: begin
        if (bus.fill_done)
          next_state = idle;
      end
      default: next_state = idle;
    endcase
  end

  always_ff @(posedge clock or negedge reset_n) begin
    if (!reset_n) begin
      state      <= idle;
      cnt        <= '0;
      mem_addr_r <= '0;
      mem_rd_r   <= 1'b0;
      mem_wr_r   <= 1'b0;
    end else begin
      state <= next_state;
      if (mem_rd_r && !mem_waitrequest)
        mem_rd_r <= 1'b0;
      if (bus.fill_word)
        cnt <= cnt + 1'b1;
      if (bus.evict) begin
        mem_addr_r <= {bus.victim_tag, cpu_index, {line_off{1'b0}}};
        mem_wr_r   <= 1'b1;
        cnt        <= '0;
      end else if (bus.fill_start) begin
        mem_addr_r <= {cpu_addr[cache_pkg::ADDR_WIDTH-1:line_off], {line_off{1'b0}}};
        mem_wr_r   <= 1'b0;
        mem_rd_r   <= 1'b1;
        cnt        <= '0;
      end else if (wr_accept) begin
        mem_addr_r <= mem_addr_r + cache_pkg::ADDR_WIDTH'(cache_pkg::BE_WIDTH);
        cnt        <= cnt + 1'b1;
      end
    end
  end

  // write data follows the victim word pointer
  always_ff @(posedge clock) begin
    if (bus.evict || wr_accept)
      mem_wr_data_r <= bus.line_word;
  end

endmodule

`default_nettype wire

/* logic/cache_top.sv */
`default_nettype none

module cache_top #(
  parameter int          line_count = 16,
  parameter logic [10:0] lfsr_seed  = 11'd101
) (
  input  wire                                clock,
  input  wire                                reset_n,

  input  wire  [cache_pkg::ADDR_WIDTH-1:0]   cpu_addr,
  input  wire                                cpu_rd,
  input  wire                                cpu_wr,
  input  wire  [cache_pkg::BE_WIDTH-1:0]     cpu_wr_be,
  input  wire  [cache_pkg::DATA_WIDTH-1:0]   cpu_wr_data,
  output wire                                cpu_rd_valid,
  output wire  [cache_pkg::DATA_WIDTH-1:0]   cpu_rd_data,
  output wire                                cpu_waitrequest,

  output wire  [cache_pkg::ADDR_WIDTH-1:0]   mem_addr_r,
  output wire                                mem_rd_r,
  output wire                                mem_wr_r,
  output wire  [cache_pkg::DATA_WIDTH-1:0]   mem_wr_data_r,
  input  wire  [cache_pkg::DATA_WIDTH-1:0]   mem_rd_data,
  input  wire                                mem_rd_valid,
  input  wire                                mem_waitrequest
);

  way_bus_if #(.line_count(line_count)) way_bus ();

  cache_ctrl #(.line_count(line_count)) cache_ctrl_i (
    .clock           (clock),
    .reset_n         (reset_n),
    .cpu_addr        (cpu_addr),
    .cpu_rd          (cpu_rd),
    .cpu_wr          (cpu_wr),
    .cpu_waitrequest (cpu_waitrequest),
    .cpu_rd_valid    (cpu_rd_valid),
    .mem_rd_valid    (mem_rd_valid),
    .mem_waitrequest (mem_waitrequest),
    .mem_addr_r      (mem_addr_r),
    .mem_rd_r        (mem_rd_r),
    .mem_wr_r        (mem_wr_r),
    .mem_wr_data_r   (mem_wr_data_r),
    .bus             (way_bus.ctrl)
  );

  cache_ways #(
    .line_count (line_count),
    .lfsr_seed  (lfsr_seed)
  ) cache_ways_i (
    .clock       (clock),
    .reset_n     (reset_n),
    .cpu_addr    (cpu_addr),
    .cpu_rd      (cpu_rd),
    .cpu_wr      (cpu_wr),
    .cpu_wr_be   (cpu_wr_be),
    .cpu_wr_data (cpu_wr_data),
    .mem_rd_data (mem_rd_data),
    .cpu_rd_data (cpu_rd_data),
    .bus         (way_bus.ways)
  );

endmodule

`default_nettype wire

/* sim/cache_props.sv */
`default_nettype none

module cache_props (
  input wire                              clock,
  input wire                              reset_n,
  input wire                              cpu_rd_valid,
  input wire                              cpu_waitrequest,
  input wire [cache_pkg::ADDR_WIDTH-1:0]  mem_addr_r,
  input wire                              mem_rd_r,
  input wire                              mem_wr_r,
  input wire [cache_pkg::DATA_WIDTH-1:0]  mem_wr_data_r,
  input wire                              mem_waitrequest
);
  timeunit 1ns;
  timeprecision 1ps;

  rd_wr_exclusive: assert property (@(posedge clock) disable iff (!reset_n)
    !(mem_rd_r && mem_wr_r))
    else $error("memory read and write strobes high together");

  rd_valid_no_wait: assert property (@(posedge clock) disable iff (!reset_n)
    cpu_rd_valid |-> !cpu_waitrequest)
    else $error("cpu_rd_valid while cpu_waitrequest is high");

  addr_aligned: assert property (@(posedge clock) disable iff (!reset_n)
    mem_addr_r[1:0] == 2'b00)
    else $error("mem_addr_r not word aligned");

  // a stalled write keeps its strobe, data and address
  wr_held: assert property (@(posedge clock) disable iff (!reset_n)
    mem_wr_r && mem_waitrequest |=>
      mem_wr_r && $stable(mem_wr_data_r) && $stable(mem_addr_r))
    else $error("memory write changed while mem_waitrequest was high");

endmodule

bind cache_top cache_props cache_props_i (.*);

`default_nettype wire

/* sim/cache_tb.sv */
`default_nettype none

module cache_tb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int clk_period = 20;
  localparam int op_count   = 430;  // cpu accesses of the whole run rounded up
  localparam int op_cycles  = 200;  // worst miss with writeback and back-pressure

  logic        clock;
  logic        reset_n;
  logic [31:0] cpu_addr;
  logic        cpu_rd;
  logic        cpu_wr;
  logic [3:0]  cpu_wr_be;
  logic [31:0] cpu_wr_data;
  wire         cpu_rd_valid;
  wire  [31:0] cpu_rd_data;
  wire         cpu_waitrequest;
  wire  [31:0] mem_addr_r;
  wire         mem_rd_r;
  wire         mem_wr_r;
  wire  [31:0] mem_wr_data_r;
  logic [31:0] mem_rd_data;
  logic        mem_rd_valid;
  logic        mem_waitrequest;

  logic [31:0] mem [logic [31:0]];     // words written back by the cache
  logic [7:0]  shadow [logic [31:0]];  // every byte the cpu wrote
  int          checks;
  int          errors;
  int          test_errors;

  cache_top #(.line_count(16), .lfsr_seed(11'd101)) cache_top_i (.*);

  initial begin
    clock = 1'b0;
    forever #(clk_period / 2) clock = ~clock;
  end

  function automatic logic [31:0] addr_hash(input logic [31:0] a);
    return (a * 32'h9e3779b1) ^ {a[15:0], a[31:16]} ^ 32'h5bd1e995;
  endfunction

  function automatic logic [31:0] mem_word(input logic [31:0] addr);
    if (mem.exists(addr))
      return mem[addr];
    return addr_hash(addr);
  endfunction

  // written bytes over the hashed background
  function automatic logic [31:0] expected_word(input logic [31:0] addr);
    logic [31:0] base;
    logic [31:0] w;
    base = {addr[31:2], 2'b00};
    w    = addr_hash(base);
    for (int b = 0; b < 4; b++) begin
      if (shadow.exists(base + 32'(b)))
        w[8*b +: 8] = shadow[base + 32'(b)];
    end
    return w;
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAILED %s: got %h, expected %h", name, got, exp);
    end
  endtask

  task automatic end_test(input string name);
    $display("test %s done, %0d errors", name, errors - test_errors);
    test_errors = errors;
  endtask

  // called 2 ns after a rising edge, returns the same amount after one
  task automatic cpu_access(input logic wr, input logic [31:0] addr, input logic [3:0] be,
                            input logic [31:0] data, output int waits);
    waits       = 0;
    cpu_addr    = addr;
    cpu_rd      = !wr;
    cpu_wr      = wr;
    cpu_wr_be   = be;
    cpu_wr_data = data;
    @(negedge clock);
    while (cpu_waitrequest) begin
      waits++;
      @(negedge clock);
    end
    if (wr) begin
      for (int b = 0; b < 4; b++) begin
        if (be[b])
          shadow[addr + 32'(b)] = data[8*b +: 8];
      end
    end
    @(posedge clock);
    #2;
    cpu_rd = 1'b0;
    cpu_wr = 1'b0;
  endtask

  // burst memory with random back-pressure and gaps between read beats
  initial begin
    logic [31:0] burst_addr;
    int          beats_left;
    burst_addr      = '0;
    beats_left      = 0;
    mem_rd_data     = '0;
    mem_rd_valid    = 1'b0;
    mem_waitrequest = 1'b0;
    forever begin
      @(posedge clock);
      if (mem_wr_r && !mem_waitrequest)
        mem[mem_addr_r] = mem_wr_data_r;
      if (mem_rd_r && !mem_waitrequest) begin
        burst_addr = mem_addr_r;
        beats_left = cache_pkg::LINE_WORDS;
      end
      #2;
      mem_waitrequest = ($urandom_range(2) == 0);  // busy about one cycle in three
      if (beats_left > 0 && $urandom_range(3) != 0) begin
        mem_rd_valid = 1'b1;
        mem_rd_data  = mem_word(burst_addr);
        burst_addr   = burst_addr + 32'd4;
        beats_left--;
      end else begin
        mem_rd_valid = 1'b0;
      end
    end
  end

  // every completed read against the reference
  always @(negedge clock) begin
    if (reset_n && cpu_rd && !cpu_waitrequest) begin
      check_value("cpu_rd_valid", 32'(cpu_rd_valid), 32'h1);
      check_value("cpu_rd_data", cpu_rd_data, expected_word(cpu_addr));
    end
  end

  initial begin
    #(op_count * op_cycles * clk_period);
    $display("timeout: the run did not finish, the CPU or memory side is stuck");
    $display("Something failed");
    $finish;
  end

  initial begin
    int          waits;
    int          found;
    logic [31:0] a;
    void'($urandom(88));
    checks      = 0;
    errors      = 0;
    test_errors = 0;
    reset_n     = 1'b0;
    cpu_addr    = '0;
    cpu_rd      = 1'b0;
    cpu_wr      = 1'b0;
    cpu_wr_be   = '0;
    cpu_wr_data = '0;
    repeat (8) @(posedge clock);
    #2;
    reset_n = 1'b1;

    repeat (6) begin  // nothing may reach memory while idle
      @(negedge clock);
      check_value("cpu_rd_valid", 32'(cpu_rd_valid), 32'h0);
      check_value("mem_rd_r", 32'(mem_rd_r), 32'h0);
      check_value("mem_wr_r", 32'(mem_wr_r), 32'h0);
      check_value("mem_addr_r", mem_addr_r, 32'h0);
    end
    @(posedge clock);
    #2;
    end_test("reset state");

    cpu_access(1'b0, 32'h100, 4'h0, 32'h0, waits);
    check_value("first read wait flag", 32'(waits != 0), 32'h1);
    for (int w = 0; w < cache_pkg::LINE_WORDS; w++) begin
      cpu_access(1'b0, 32'h100 + 32'(4 * w), 4'h0, 32'h0, waits);
      check_value("hit wait cycles", 32'(waits), 32'h0);
    end
    end_test("line fill and read hits");

    cpu_access(1'b1, 32'h104, 4'b0101, 32'ha1b2c3d4, waits);
    cpu_access(1'b0, 32'h104, 4'h0, 32'h0, waits);
    end_test("partial byte write");

    // five tags into set 5 push one dirty line out
    for (int t = 0; t < 5; t++)
      cpu_access(1'b1, 32'h1050 + 32'(t << 8), 4'hf, 32'hc0de0000 + 32'(t), waits);
    found = 0;
    for (int t = 0; t < 5; t++) begin
      a = 32'h1050 + 32'(t << 8);
      if (mem.exists(a)) begin
        found++;
        check_value("evicted memory word", mem[a], expected_word(a));
      end
    end
    check_value("evicted lines", 32'(found), 32'h1);
    for (int t = 0; t < 5; t++)
      cpu_access(1'b0, 32'h1050 + 32'(t << 8), 4'h0, 32'h0, waits);
    end_test("dirty eviction");

    repeat (400) begin  // 2 KB window gives eight tags per set
      a = 32'h2000 + {21'b0, 9'($urandom_range(511)), 2'b00};
      if ($urandom_range(1) == 0)
        cpu_access(1'b1, a, 4'($urandom_range(15, 1)), $urandom, waits);
      else
        cpu_access(1'b0, a, 4'h0, 32'h0, waits);
    end
    end_test("random traffic");

    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0)
      $display("Everything OK");
    else
      $display("Something failed");
    $finish;
  end

endmodule

`default_nettype wire

/* sim.f */
logic/cache_pkg.sv
logic/way_bus_if.sv
logic/victim_select.sv
logic/cache_ways.sv
logic/cache_ctrl.sv
logic/cache_top.sv
sim/cache_props.sv
sim/cache_tb.sv

/* run.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --timescale 1ns/1ps \
  -f sim.f --top-module cache_tb -o cache_sim
./obj_dir/cache_sim | tee sim.log
grep -q "Everything OK" sim.log
echo "simulation passed"
